//--- build.f
+incdir+rtl
rtl/fpga_bus_pkg.sv
rtl/cpu_bus_decoder.sv
rtl/controller_regs.sv
rtl/mod_mem.sv
rtl/drive_mem.sv
rtl/fpga_bus_top.sv
verif/tb_fpga_bus.sv

//--- rtl/controller_regs.sv
`default_nettype none

`include "fpga_bus_consts.svh"

module controller_regs (
  input wire CPU_CKIO,
  input wire rst_n,
  input wire fpga_bus_pkg::bus_wr_t bus_wr,
  input wire [13:0] rd_addr,
  output logic [15:0] reg_rdata,
  output logic mod_wr_page,
  output logic drive_page,
  output logic [15:0] mod_cycle,
  output logic [31:0] mod_freq_div
);

  // register storage
  logic [15:0] ctl_flag;
  logic [15:0] mod_mem_wr_page;
  logic [15:0] mod_freq_div_0;
  logic [15:0] mod_freq_div_1;
  // write pulse aimed at this bank
  logic ctl_wr;

  assign ctl_wr = bus_wr.wr & (bus_wr.sel == `BRAM_SELECT_CONTROLLER);

  // address decode on the write pulse
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      ctl_flag <= '0;
      mod_mem_wr_page <= '0;
      mod_cycle <= '0;
      mod_freq_div_0 <= '0;
      mod_freq_div_1 <= '0;
    end else if (ctl_wr) begin
      case (bus_wr.addr)
        `ADDR_CTL_FLAG: ctl_flag <= bus_wr.data.raw;
        `ADDR_MOD_MEM_WR_PAGE: mod_mem_wr_page <= bus_wr.data.raw;
        `ADDR_MOD_CYCLE: mod_cycle <= bus_wr.data.raw;
        `ADDR_MOD_FREQ_DIV_0: mod_freq_div_0 <= bus_wr.data.raw;
        `ADDR_MOD_FREQ_DIV_1: mod_freq_div_1 <= bus_wr.data.raw;
        // info word and unmapped addresses drop the write
        default: begin
        end
      endcase
    end
  end

  // read mux on the held read address
  always_comb begin
    case (rd_addr)
      `ADDR_CTL_FLAG: reg_rdata = ctl_flag;
      `ADDR_MOD_MEM_WR_PAGE: reg_rdata = mod_mem_wr_page;
      `ADDR_MOD_CYCLE: reg_rdata = mod_cycle;
      `ADDR_MOD_FREQ_DIV_0: reg_rdata = mod_freq_div_0;
      `ADDR_MOD_FREQ_DIV_1: reg_rdata = mod_freq_div_1;
      `ADDR_FPGA_INFO: reg_rdata = `FPGA_INFO_WORD;
      default: reg_rdata = '0;
    endcase
  end

  // drive read page from the flag register
  assign drive_page = ctl_flag[`CTL_FLAG_DRIVE_PAGE_BIT];

  // only two modulation pages exist
  assign mod_wr_page = mod_mem_wr_page[0];

  // halves joined for the downstream divider
  assign mod_freq_div = {mod_freq_div_1, mod_freq_div_0};

endmodule

`default_nettype wire

//--- rtl/cpu_bus_decoder.sv
`default_nettype none

`include "fpga_bus_consts.svh"

module cpu_bus_decoder (
  input wire CPU_CKIO,
  input wire rst_n,
  input wire [16:1] cpu_addr,
  input wire cpu_cs1_n,
  input wire cpu_we0_n,
  input wire cpu_rd_n,
  input wire [15:0] cpu_data_in,
  input wire [15:0] reg_rdata,
  output fpga_bus_pkg::bus_wr_t bus_wr,
  output logic [13:0] rd_addr,
  output logic [15:0] cpu_data_out
);
  import fpga_bus_pkg::*;

  // strobes after one register stage
  logic cs_q;
  logic we_q;
  logic rd_q;
  // previous registered write strobe for edge detect
  logic we_qq;
  // address and data sampled with the strobes
  logic [16:1] addr_q;
  bus_word_u data_q;
  // write broadcast fields
  logic wr_pulse;
  logic [1:0] wr_sel;
  logic [13:0] wr_addr;
  bus_word_u wr_data;
  // select code of the held read address
  logic [1:0] rd_sel;
  logic wr_start;

  // falling edge of registered WE while CS is low
  assign wr_start = ~cs_q & ~we_q & we_qq;

  // strobes idle high
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cs_q <= 1'b1;
      we_q <= 1'b1;
      we_qq <= 1'b1;
      rd_q <= 1'b1;
    end else begin
      cs_q <= cpu_cs1_n;
      we_q <= cpu_we0_n;
      we_qq <= we_q;
      rd_q <= cpu_rd_n;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q.raw <= cpu_data_in;
  end

  // one pulse per write cycle
  // held WE does not retrigger
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_pulse <= 1'b0;
    end else begin
      wr_pulse <= wr_start;
    end
  end

  // payload captured alongside the pulse
  always_ff @(posedge CPU_CKIO) begin
    if (wr_start) begin
      wr_sel <= addr_q[16:15];
      wr_addr <= addr_q[14:1];
      wr_data <= data_q;
    end
  end

  assign bus_wr = '{wr: wr_pulse, sel: wr_sel, addr: wr_addr, data: wr_data};

  // read address held until the next read cycle
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      rd_addr <= '0;
      rd_sel <= `BRAM_SELECT_CONTROLLER;
    end else if (~cs_q & we_q & ~rd_q) begin
      rd_addr <= addr_q[14:1];
      rd_sel <= addr_q[16:15];
    end
  end

  // only the register bank is readable
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cpu_data_out <= '0;
    end else if (rd_sel == `BRAM_SELECT_CONTROLLER) begin
      cpu_data_out <= reg_rdata;
    end else begin
      cpu_data_out <= '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/drive_mem.sv
`default_nettype none

`include "fpga_bus_consts.svh"

module drive_mem (
  input wire CPU_CKIO,
  input wire fpga_bus_pkg::bus_wr_t bus_wr,
  input wire drive_page,
  input wire [7:0] drive_rd_idx,
  output fpga_bus_pkg::drive_entry_t drive_entry
);
  import fpga_bus_pkg::*;

  // transducer index width
  localparam int IDX_W = $clog2(`NUM_TRANSDUCERS);
  // two pages back to back
  localparam int DEPTH = 2 * `NUM_TRANSDUCERS;

  drive_entry_t entries[DEPTH];
  // page bit then transducer index
  logic [IDX_W:0] wr_idx;
  logic [IDX_W:0] rd_idx;
  logic wr_en;

  // address bit 8 is the page
  assign wr_idx = bus_wr.addr[IDX_W:0];

  // upper address bits must be clear
  assign wr_en = bus_wr.wr & (bus_wr.sel == `BRAM_SELECT_NORMAL) &
                 (bus_wr.addr[13:IDX_W+1] == '0);

  // read page set by the control flag
  assign rd_idx = {drive_page, drive_rd_idx};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      entries[wr_idx] <= bus_wr.data.drive;
    end
  end

  // one cycle read latency
  always_ff @(posedge CPU_CKIO) begin
    drive_entry <= entries[rd_idx];
  end

endmodule

`default_nettype wire

//--- rtl/fpga_bus_consts.svh
`ifndef FPGA_BUS_CONSTS_SVH
`define FPGA_BUS_CONSTS_SVH

// target select codes on CPU_ADDR[16:15]
`define BRAM_SELECT_CONTROLLER 2'd0
`define BRAM_SELECT_MOD 2'd1
`define BRAM_SELECT_NORMAL 2'd2

// controller register map in word addresses
`define ADDR_CTL_FLAG 14'h000
`define ADDR_MOD_MEM_WR_PAGE 14'h001
`define ADDR_MOD_CYCLE 14'h002
// divider is split into two 16-bit halves
`define ADDR_MOD_FREQ_DIV_0 14'h003
`define ADDR_MOD_FREQ_DIV_1 14'h004
// read-only identification word
`define ADDR_FPGA_INFO 14'h005

`define FPGA_INFO_WORD 16'h00A5

// control flag bit that picks the drive read page
`define CTL_FLAG_DRIVE_PAGE_BIT 0

// modulation memory words per page
// each word carries two 8-bit samples
`define MOD_WORDS_PER_PAGE 2048

// drive entries per page
`define NUM_TRANSDUCERS 256

`endif

//--- rtl/fpga_bus_pkg.sv
`default_nettype none

package fpga_bus_pkg;

  // one transducer drive setting
  // intensity sits in the upper byte
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_entry_t;

  // two modulation samples in one bus word
  // sample_lo holds the even sample index
  typedef struct packed {
    logic [7:0] sample_hi;
    logic [7:0] sample_lo;
  } mod_pair_t;

  // the 16-bit CPU data word
  // drive memory and modulation memory see it differently
  typedef union packed {
    logic [15:0] raw;
    drive_entry_t drive;
    mod_pair_t mod;
  } bus_word_u;

  // decoded write broadcast to every target
  // wr is high for exactly one cycle per CPU write
  typedef struct packed {
    logic wr;
    // target select code
    logic [1:0] sel;
    // word address inside the target
    logic [13:0] addr;
    bus_word_u data;
  } bus_wr_t;

endpackage

`default_nettype wire

//--- rtl/fpga_bus_top.sv
`default_nettype none

module fpga_bus_top (
  input wire CPU_CKIO,
  input wire rst_n,
  // CPU bus
  input wire [16:1] CPU_ADDR,
  input wire CPU_CS1_N,
  input wire CPU_WE0_N,
  input wire CPU_RD_N,
  input wire [15:0] cpu_data_in,
  output logic [15:0] cpu_data_out,
  // downstream read ports
  input wire [12:0] mod_rd_idx,
  input wire [7:0] drive_rd_idx,
  output logic [7:0] mod_sample,
  output fpga_bus_pkg::drive_entry_t drive_entry,
  // exported configuration
  output logic [15:0] mod_cycle,
  output logic [31:0] mod_freq_div
);
  import fpga_bus_pkg::*;

  // write broadcast shared by all targets
  bus_wr_t bus_wr;
  // register read path
  logic [13:0] rd_addr;
  logic [15:0] reg_rdata;
  // page controls from the register bank
  logic mod_wr_page;
  logic drive_page;

  cpu_bus_decoder u_decoder (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .cpu_addr(CPU_ADDR),
    .cpu_cs1_n(CPU_CS1_N),
    .cpu_we0_n(CPU_WE0_N),
    .cpu_rd_n(CPU_RD_N),
    .cpu_data_in(cpu_data_in),
    .reg_rdata(reg_rdata),
    .bus_wr(bus_wr),
    .rd_addr(rd_addr),
    .cpu_data_out(cpu_data_out)
  );

  controller_regs u_regs (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .bus_wr(bus_wr),
    .rd_addr(rd_addr),
    .reg_rdata(reg_rdata),
    .mod_wr_page(mod_wr_page),
    .drive_page(drive_page),
    .mod_cycle(mod_cycle),
    .mod_freq_div(mod_freq_div)
  );

  // modulation samples
  mod_mem u_mod_mem (
    .CPU_CKIO(CPU_CKIO),
    .bus_wr(bus_wr),
    .mod_wr_page(mod_wr_page),
    .mod_rd_idx(mod_rd_idx),
    .mod_sample(mod_sample)
  );

  // per-transducer intensity and phase
  drive_mem u_drive_mem (
    .CPU_CKIO(CPU_CKIO),
    .bus_wr(bus_wr),
    .drive_page(drive_page),
    .drive_rd_idx(drive_rd_idx),
    .drive_entry(drive_entry)
  );

endmodule

`default_nettype wire

//--- rtl/mod_mem.sv
`default_nettype none

`include "fpga_bus_consts.svh"

module mod_mem (
  input wire CPU_CKIO,
  input wire fpga_bus_pkg::bus_wr_t bus_wr,
  input wire mod_wr_page,
  input wire [12:0] mod_rd_idx,
  output logic [7:0] mod_sample
);
  import fpga_bus_pkg::*;

  // word address bits inside one page
  localparam int WORD_AW = $clog2(`MOD_WORDS_PER_PAGE);
  // both pages stacked in each bank
  localparam int BANK_DEPTH = 2 * `MOD_WORDS_PER_PAGE;

  // even samples in one bank and odd samples in the other
  logic [7:0] even_bank[BANK_DEPTH];
  logic [7:0] odd_bank[BANK_DEPTH];
  mod_pair_t wr_pair;
  // page then word address
  logic [WORD_AW:0] wr_idx;
  logic [WORD_AW:0] rd_word;
  logic wr_en;

  assign wr_pair = bus_wr.data.mod;
  assign wr_idx = {mod_wr_page, bus_wr.addr[WORD_AW-1:0]};

  // writes past the page end are dropped
  assign wr_en = bus_wr.wr & (bus_wr.sel == `BRAM_SELECT_MOD) &
                 (bus_wr.addr < 14'(`MOD_WORDS_PER_PAGE));

  // byte index LSB picks the bank
  assign rd_word = mod_rd_idx[12:1];

  // both samples of a word land in one cycle
  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      even_bank[wr_idx] <= wr_pair.sample_lo;
      odd_bank[wr_idx] <= wr_pair.sample_hi;
    end
  end

  // registered byte read
  always_ff @(posedge CPU_CKIO) begin
    if (mod_rd_idx[0]) begin
      mod_sample <= odd_bank[rd_word];
    end else begin
      mod_sample <= even_bank[rd_word];
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the fpga bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fpga_bus -f build.f -o tb_fpga_bus \
  > build.log 2>&1 || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/tb_fpga_bus > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "simulation did not run"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation passed"

//--- verif/tb_fpga_bus.sv
`default_nettype none

`include "fpga_bus_consts.svh"

module tb_fpga_bus;
  timeunit 1ns;
  timeprecision 1ps;
  import fpga_bus_pkg::*;

  // row kinds of the stimulus table
  typedef enum logic [2:0] {
    OP_WRITE, OP_WRITE_LONG, OP_READ, OP_MOD_RD,
    OP_DRV_RD, OP_CYCLE, OP_DIV_LO, OP_DIV_HI
  } op_e;

  typedef struct packed {
    op_e op;
    logic [1:0] sel;
    logic [13:0] addr;
    logic [15:0] data;
    logic [15:0] exp_val;
  } row_t;

  logic CPU_CKIO;
  logic rst_n;
  logic [16:1] CPU_ADDR;
  logic CPU_CS1_N;
  logic CPU_WE0_N;
  logic CPU_RD_N;
  logic [15:0] cpu_data_in;
  logic [15:0] cpu_data_out;
  logic [12:0] mod_rd_idx;
  logic [7:0] drive_rd_idx;
  logic [7:0] mod_sample;
  drive_entry_t drive_entry;
  logic [15:0] mod_cycle;
  logic [31:0] mod_freq_div;

  row_t stim[$];
  // expected memory contents, byte index and page-then-index
  logic [7:0] mod_model[4 * `MOD_WORDS_PER_PAGE];
  drive_entry_t drive_model[2 * `NUM_TRANSDUCERS];
  logic model_mod_page;
  logic model_drive_page;
  int error_count;
  int check_count;
  int wr_pulse_count;
  int cycle_count;
  int cycle_limit;
  int unsigned seed_ret;

  fpga_bus_top dut (
    .CPU_CKIO(CPU_CKIO), .rst_n(rst_n), .CPU_ADDR(CPU_ADDR), .CPU_CS1_N(CPU_CS1_N),
    .CPU_WE0_N(CPU_WE0_N), .CPU_RD_N(CPU_RD_N), .cpu_data_in(cpu_data_in),
    .cpu_data_out(cpu_data_out), .mod_rd_idx(mod_rd_idx), .drive_rd_idx(drive_rd_idx),
    .mod_sample(mod_sample), .drive_entry(drive_entry), .mod_cycle(mod_cycle),
    .mod_freq_div(mod_freq_div)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #2 CPU_CKIO = ~CPU_CKIO;
  end

  // count broadcast write pulses, mid-cycle where they are stable
  always @(negedge CPU_CKIO) begin
    if (rst_n && dut.bus_wr.wr) begin
      wr_pulse_count++;
    end
  end

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sample(input logic [7:0] got, input logic [7:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s gave sample %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_entry(input drive_entry_t got, input drive_entry_t exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s gave intensity %h phase %h, expected %h %h",
               $time, what, got.intensity, got.phase, exp.intensity, exp.phase);
    end
  endtask

  function automatic void push_row(op_e op, logic [1:0] sel, logic [13:0] addr,
                                   logic [15:0] data, logic [15:0] exp_val);
    row_t r;
    r = '{op: op, sel: sel, addr: addr, data: data, exp_val: exp_val};
    stim.push_back(r);
  endfunction

  // write row plus the effect on the expected memory image
  function automatic void write_row(logic [1:0] sel, logic [13:0] addr, logic [15:0] data,
                                    bit held);
    int base;
    push_row(held ? OP_WRITE_LONG : OP_WRITE, sel, addr, data, 16'h0000);
    if (sel == `BRAM_SELECT_CONTROLLER) begin
      if (addr == `ADDR_MOD_MEM_WR_PAGE) model_mod_page = data[0];
      if (addr == `ADDR_CTL_FLAG) model_drive_page = data[`CTL_FLAG_DRIVE_PAGE_BIT];
    end else if (sel == `BRAM_SELECT_MOD && int'(addr) < `MOD_WORDS_PER_PAGE) begin
      // two bytes per word, even byte is the low sample
      base = int'(model_mod_page) * 2 * `MOD_WORDS_PER_PAGE + 2 * int'(addr);
      mod_model[base] = data[7:0];
      mod_model[base + 1] = data[15:8];
    end else if (sel == `BRAM_SELECT_NORMAL && addr[13:9] == 5'd0) begin
      // intensity in the upper byte, phase in the lower
      drive_model[addr[8:0]] = '{intensity: data[15:8], phase: data[7:0]};
    end
  endfunction

  function automatic void read_row(logic [1:0] sel, logic [13:0] addr, logic [15:0] exp_val);
    push_row(OP_READ, sel, addr, 16'h0000, exp_val);
  endfunction

  function automatic void mod_row(int idx);
    push_row(OP_MOD_RD, 2'd0, 14'(idx), 16'h0000, {8'h00, mod_model[idx]});
  endfunction

  function automatic void drive_row(int idx);
    push_row(OP_DRV_RD, 2'd0, 14'(idx), 16'h0000, drive_model[{model_drive_page, 8'(idx)}]);
  endfunction

  function automatic void build_stimulus();
    int mod_addrs[4] = '{0, 1, 100, 2047};
    int drv_idx[3] = '{0, 7, 255};
    model_mod_page = 1'b0;
    model_drive_page = 1'b0;
    // reset values of the whole register map
    for (int a = 0; a < 6; a++) begin
      read_row(`BRAM_SELECT_CONTROLLER, 14'(a), (a == 5) ? `FPGA_INFO_WORD : 16'h0000);
    end
    read_row(`BRAM_SELECT_CONTROLLER, 14'h006, 16'h0000);
    read_row(`BRAM_SELECT_CONTROLLER, 14'h3fff, 16'h0000);
    // configuration registers and their exported copies
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h1234, 1'b0);
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV_0, 16'hbeef, 1'b0);
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV_1, 16'h0042, 1'b0);
    write_row(`BRAM_SELECT_CONTROLLER, 14'h010, 16'hffff, 1'b0);
    read_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h1234);
    read_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV_0, 16'hbeef);
    read_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV_1, 16'h0042);
    read_row(`BRAM_SELECT_CONTROLLER, 14'h010, 16'h0000);
    push_row(OP_CYCLE, 2'd0, 14'h0, 16'h0, 16'h1234);
    push_row(OP_DIV_LO, 2'd0, 14'h0, 16'h0, 16'hbeef);
    push_row(OP_DIV_HI, 2'd0, 14'h0, 16'h0, 16'h0042);
    // held WE writes once, later write wins
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h5a5a, 1'b1);
    read_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h5a5a);
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h0f0f, 1'b0);
    read_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'h0f0f);
    // modulation pages 0 and 1
    for (int p = 0; p < 2; p++) begin
      write_row(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_MEM_WR_PAGE, 16'(p), 1'b0);
      foreach (mod_addrs[k]) begin
        write_row(`BRAM_SELECT_MOD, 14'(mod_addrs[k]), 16'($urandom), 1'b0);
      end
    end
    // past the page end, must not alias onto word 0
    write_row(`BRAM_SELECT_MOD, 14'd2048, 16'($urandom), 1'b0);
    for (int p = 0; p < 2; p++) begin
      foreach (mod_addrs[k]) begin
        mod_row(p * 4096 + 2 * mod_addrs[k]);
        mod_row(p * 4096 + 2 * mod_addrs[k] + 1);
      end
    end
    // drive pages, then an out-of-range write
    for (int p = 0; p < 2; p++) begin
      foreach (drv_idx[k]) begin
        write_row(`BRAM_SELECT_NORMAL, 14'(p * 256 + drv_idx[k]), 16'($urandom), 1'b0);
      end
    end
    write_row(`BRAM_SELECT_NORMAL, 14'h207, 16'($urandom), 1'b0);
    foreach (drv_idx[k]) drive_row(drv_idx[k]);
    write_row(`BRAM_SELECT_CONTROLLER, `ADDR_CTL_FLAG, 16'h0001, 1'b0);
    foreach (drv_idx[k]) drive_row(drv_idx[k]);
    // memories are write-only from the CPU
    read_row(`BRAM_SELECT_MOD, 14'h000, 16'h0000);
    read_row(`BRAM_SELECT_NORMAL, 14'h000, 16'h0000);
  endfunction

  // called on a falling edge, returns on one
  task automatic bus_write(input logic [1:0] sel, input logic [13:0] addr,
                           input logic [15:0] data, input int we_cycles);
    int pulses_before;
    pulses_before = wr_pulse_count;
    CPU_ADDR = {sel, addr};
    cpu_data_in = data;
    CPU_CS1_N = 1'b0;
    @(negedge CPU_CKIO);
    CPU_WE0_N = 1'b0;
    repeat (we_cycles) @(negedge CPU_CKIO);
    CPU_WE0_N = 1'b1;
    @(negedge CPU_CKIO);
    CPU_CS1_N = 1'b1;
    @(negedge CPU_CKIO);
    if (wr_pulse_count - pulses_before != 1) begin
      error_count++;
      $display("FAILED at %0t ns: write to %h gave %0d pulses, expected 1",
               $time, {sel, addr}, wr_pulse_count - pulses_before);
    end
  endtask

  // address sampled, then register stage, then output stage
  task automatic bus_read(input logic [1:0] sel, input logic [13:0] addr,
                          output logic [15:0] data);
    CPU_ADDR = {sel, addr};
    CPU_CS1_N = 1'b0;
    CPU_RD_N = 1'b0;
    repeat (3) @(negedge CPU_CKIO);
    data = cpu_data_out;
    CPU_RD_N = 1'b1;
    CPU_CS1_N = 1'b1;
    @(negedge CPU_CKIO);
  endtask

  task automatic sample_mod(input logic [12:0] idx, output logic [7:0] sample);
    mod_rd_idx = idx;
    @(negedge CPU_CKIO);
    sample = mod_sample;
  endtask

  task automatic sample_drive(input logic [7:0] idx, output drive_entry_t entry);
    drive_rd_idx = idx;
    @(negedge CPU_CKIO);
    entry = drive_entry;
  endtask

  // watchdog on a cycle budget from the table length
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge CPU_CKIO);
      cycle_count++;
    end
    $display("timeout: test did not finish within %0d cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [15:0] rd_word;
    logic [7:0] rd_sample;
    drive_entry_t rd_entry;
    string what;
    rst_n = 1'b0;
    CPU_ADDR = '0;
    CPU_CS1_N = 1'b1;
    CPU_WE0_N = 1'b1;
    CPU_RD_N = 1'b1;
    cpu_data_in = '0;
    mod_rd_idx = '0;
    drive_rd_idx = '0;
    seed_ret = $urandom(32'hc4b2);
    build_stimulus();
    cycle_limit = stim.size() * 10 + 200;
    repeat (3) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    rst_n = 1'b1;
    @(negedge CPU_CKIO);
    foreach (stim[i]) begin
      what = $sformatf("row %0d sel %0d addr %h", i, stim[i].sel, stim[i].addr);
      case (stim[i].op)
        OP_WRITE: bus_write(stim[i].sel, stim[i].addr, stim[i].data, 2);
        OP_WRITE_LONG: bus_write(stim[i].sel, stim[i].addr, stim[i].data, 5);
        OP_READ: begin
          bus_read(stim[i].sel, stim[i].addr, rd_word);
          check_word(rd_word, stim[i].exp_val, what);
        end
        OP_MOD_RD: begin
          sample_mod(stim[i].addr[12:0], rd_sample);
          check_sample(rd_sample, stim[i].exp_val[7:0], what);
        end
        OP_DRV_RD: begin
          sample_drive(stim[i].addr[7:0], rd_entry);
          check_entry(rd_entry, drive_entry_t'(stim[i].exp_val), what);
        end
        OP_CYCLE: check_word(mod_cycle, stim[i].exp_val, "mod_cycle output");
        OP_DIV_LO: check_word(mod_freq_div[15:0], stim[i].exp_val, "mod_freq_div low half");
        default: check_word(mod_freq_div[31:16], stim[i].exp_val, "mod_freq_div high half");
      endcase
    end
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
